// ==== logic/ecc_pkg.sv ====
package ecc_pkg;

    localparam int FIELD_W   = 16;
    localparam int KEY_W     = 8;
    localparam int BIT_W     = $clog2(KEY_W - 1);     // index of the scanned key bit
    localparam int DBL_LEN   = 13;
    localparam int ADD_LEN   = 10;
    localparam int PC_W      = $clog2(DBL_LEN);
    localparam int MUL_CNT_W = $clog2(FIELD_W) + 1;

    typedef logic [FIELD_W-1:0] field_t;
    typedef logic [KEY_W-1:0]   key_t;

    typedef enum logic [1:0] {
        GF_ADD = 2'b00,
        GF_SUB = 2'b01,
        GF_MUL = 2'b10,
        GF_DIV = 2'b11
    } gf_opcode_e;

    // nine registers, so four select bits
    typedef enum logic [3:0] {
        REG_QX,
        REG_QY,
        REG_PX,
        REG_PY,
        REG_T1,
        REG_T2,
        REG_T3,
        REG_A,
        REG_ZERO                                    // reads as 0, for copies
    } reg_sel_e;

    typedef struct packed {
        gf_opcode_e opcode;
        reg_sel_e   src_a;
        reg_sel_e   src_b;
        reg_sel_e   dst;
    } micro_op_t;

    // Q = 2Q, slope kept in T1
    localparam micro_op_t DBL_PROG [DBL_LEN] = '{
        '{GF_MUL, REG_QX, REG_QX,   REG_T1},
        '{GF_ADD, REG_T1, REG_T1,   REG_T2},
        '{GF_ADD, REG_T2, REG_T1,   REG_T2},        // 3x^2
        '{GF_ADD, REG_T2, REG_A,    REG_T2},
        '{GF_ADD, REG_QY, REG_QY,   REG_T1},
        '{GF_DIV, REG_T2, REG_T1,   REG_T1},        // lambda
        '{GF_MUL, REG_T1, REG_T1,   REG_T2},
        '{GF_SUB, REG_T2, REG_QX,   REG_T2},
        '{GF_SUB, REG_T2, REG_QX,   REG_T3},        // new x
        '{GF_SUB, REG_QX, REG_T3,   REG_T2},
        '{GF_MUL, REG_T1, REG_T2,   REG_T2},
        '{GF_SUB, REG_T2, REG_QY,   REG_QY},
        '{GF_ADD, REG_T3, REG_ZERO, REG_QX}
    };

    // Q = Q + P
    localparam micro_op_t ADD_PROG [ADD_LEN] = '{
        '{GF_SUB, REG_PX, REG_QX,   REG_T1},
        '{GF_SUB, REG_PY, REG_QY,   REG_T2},
        '{GF_DIV, REG_T2, REG_T1,   REG_T1},        // lambda
        '{GF_MUL, REG_T1, REG_T1,   REG_T2},
        '{GF_SUB, REG_T2, REG_QX,   REG_T2},
        '{GF_SUB, REG_T2, REG_PX,   REG_T3},        // new x
        '{GF_SUB, REG_QX, REG_T3,   REG_T2},
        '{GF_MUL, REG_T1, REG_T2,   REG_T2},
        '{GF_SUB, REG_T2, REG_QY,   REG_QY},
        '{GF_ADD, REG_T3, REG_ZERO, REG_QX}
    };

endpackage

// ==== logic/gf_op_if.sv ====
interface gf_op_if import ecc_pkg::*; ();

    logic       req_valid;
    logic       req_ready;
    gf_opcode_e opcode;
    reg_sel_e   src_a_sel;
    reg_sel_e   src_b_sel;
    reg_sel_e   dst_sel;
    field_t     operand_a;
    field_t     operand_b;
    field_t     result;
    logic       rsp_valid;                          // one cycle, result valid with it

    modport sequencer (
        output req_valid,
        output opcode,
        output src_a_sel,
        output src_b_sel,
        output dst_sel,
        input  req_ready,
        input  rsp_valid
    );

    modport regfile (
        input  src_a_sel,
        input  src_b_sel,
        input  dst_sel,
        input  result,
        input  rsp_valid,
        output operand_a,
        output operand_b
    );

    modport arith (
        input  req_valid,
        input  opcode,
        input  operand_a,
        input  operand_b,
        output req_ready,
        output result,
        output rsp_valid
    );

endinterface

// ==== logic/point_mult_sequencer.sv ====
module point_mult_sequencer import ecc_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_reset,
    input  logic        i_start,
    input  key_t        i_key,
    output logic        o_busy,
    output logic        o_done,
    gf_op_if.sequencer  op
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_e;

    state_e            state;
    logic [KEY_W-2:0]  key_q;                       // msb always taken as 1
    logic [BIT_W-1:0]  bit_idx;
    logic [PC_W-1:0]   pc;
    logic              in_add;                      // running the addition program
    logic              done_q;
    micro_op_t         cur_op;
    logic              prog_end;
    logic              bit_end;

    always_comb
    begin
        if (in_add)
        begin
            cur_op = ADD_PROG[pc];
        end
        else
        begin
            cur_op = DBL_PROG[pc];
        end
    end

    always_comb
    begin
        if (in_add)
        begin
            prog_end = (pc == PC_W'(ADD_LEN - 1));
        end
        else
        begin
            prog_end = (pc == PC_W'(DBL_LEN - 1));
        end
    end

    // a zero bit ends after doubling
    assign bit_end = prog_end && (in_add || !key_q[bit_idx]);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state   <= ST_IDLE;
            key_q   <= '0;
            bit_idx <= '0;
            pc      <= '0;
            in_add  <= 1'b0;
            done_q  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (i_start)
                    begin
                        key_q   <= i_key[KEY_W-2:0];
                        bit_idx <= BIT_W'(KEY_W - 2);
                        pc      <= '0;
                        in_add  <= 1'b0;
                        state   <= ST_ISSUE;
                    end
                end
                ST_ISSUE:
                begin
                    if (op.req_ready)
                    begin
                        state <= ST_WAIT;           // accepted
                    end
                end
                ST_WAIT:
                begin
                    if (op.rsp_valid)
                    begin
                        if (!prog_end)
                        begin
                            pc    <= pc + 1'b1;
                            state <= ST_ISSUE;
                        end
                        else if (!bit_end)
                        begin
                            in_add <= 1'b1;         // bit set, add P
                            pc     <= '0;
                            state  <= ST_ISSUE;
                        end
                        else if (bit_idx != '0)
                        begin
                            bit_idx <= bit_idx - 1'b1;
                            in_add  <= 1'b0;
                            pc      <= '0;
                            state   <= ST_ISSUE;
                        end
                        else
                        begin
                            done_q <= 1'b1;
                            state  <= ST_IDLE;
                        end
                    end
                end
                default:
                begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign op.req_valid = (state == ST_ISSUE);
    assign op.opcode    = cur_op.opcode;
    assign op.src_a_sel = cur_op.src_a;
    assign op.src_b_sel = cur_op.src_b;
    assign op.dst_sel   = cur_op.dst;

    assign o_busy = (state != ST_IDLE);
    assign o_done = done_q;

endmodule

// ==== logic/point_register_file.sv ====
module point_register_file import ecc_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_load,
    input  field_t     i_px,
    input  field_t     i_py,
    input  field_t     i_a,
    output field_t     o_qx,
    output field_t     o_qy,
    gf_op_if.regfile   op
);

    field_t qx;
    field_t qy;
    field_t px;
    field_t py;
    field_t t1;
    field_t t2;
    field_t t3;
    field_t a_reg;

    function automatic field_t read_reg(reg_sel_e sel);
        case (sel)
            REG_QX:  return qx;
            REG_QY:  return qy;
            REG_PX:  return px;
            REG_PY:  return py;
            REG_T1:  return t1;
            REG_T2:  return t2;
            REG_T3:  return t3;
            REG_A:   return a_reg;
            default: return '0;                     // REG_ZERO
        endcase
    endfunction

    always_comb
    begin
        op.operand_a = read_reg(op.src_a_sel);
        op.operand_b = read_reg(op.src_b_sel);
    end

    // Q starts as P
    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            qx <= '0;
            qy <= '0;
        end
        else if (i_load)
        begin
            qx <= i_px;
            qy <= i_py;
        end
        else if (op.rsp_valid && op.dst_sel == REG_QX)
        begin
            qx <= op.result;
        end
        else if (op.rsp_valid && op.dst_sel == REG_QY)
        begin
            qy <= op.result;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (i_load)
        begin
            px    <= i_px;
            py    <= i_py;
            a_reg <= i_a;
        end
        else if (op.rsp_valid)
        begin
            case (op.dst_sel)
                REG_T1:  t1 <= op.result;
                REG_T2:  t2 <= op.result;
                REG_T3:  t3 <= op.result;
                default: ;                          // Q handled above
            endcase
        end
    end

    assign o_qx = qx;
    assign o_qy = qy;

endmodule

// ==== logic/gf_arith_unit.sv ====
module gf_arith_unit import ecc_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  field_t    i_prime,
    gf_op_if.arith    op
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MUL,
        ST_EXP_CHK,
        ST_EXP_MUL,
        ST_EXP_SQR,
        ST_DIV_MUL
    } state_e;

    state_e                 state;
    logic                   accept;
    logic                   rsp_valid_q;
    field_t                 rsp_data;
    field_t                 exp_q;                  // remaining exponent bits
    field_t                 base_q;
    field_t                 pow_q;
    field_t                 div_a_q;
    field_t                 m_x;
    field_t                 m_y;
    field_t                 m_acc;
    logic [MUL_CNT_W-1:0]   m_cnt;
    logic                   eng_start;
    logic                   eng_idle;
    field_t                 eng_x;
    field_t                 eng_y;

    function automatic field_t add_mod(field_t a, field_t b, field_t p);
        logic [FIELD_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        if (sum >= {1'b0, p})
            sum = sum - {1'b0, p};
        return sum[FIELD_W-1:0];
    endfunction

    function automatic field_t sub_mod(field_t a, field_t b, field_t p);
        field_t diff;
        diff = a - b;
        if (a < b)
            diff = diff + p;
        return diff;
    endfunction

    assign accept   = op.req_valid && op.req_ready;
    assign eng_idle = (m_cnt == '0);

    // multiplier operands for each step
    always_comb
    begin
        eng_start = 1'b0;
        eng_x     = base_q;
        eng_y     = base_q;
        case (state)
            ST_IDLE:
            begin
                if (accept && op.opcode == GF_MUL)
                begin
                    eng_start = 1'b1;
                    eng_x     = op.operand_a;
                    eng_y     = op.operand_b;
                end
            end
            ST_EXP_CHK:
            begin
                eng_start = 1'b1;
                if (exp_q == '0)
                begin
                    eng_x = pow_q;                  // final pow * a
                    eng_y = div_a_q;
                end
                else if (exp_q[0])
                begin
                    eng_x = pow_q;
                    eng_y = base_q;
                end
            end
            ST_EXP_MUL:
            begin
                eng_start = eng_idle;               // then square the base
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            m_cnt <= '0;
        end
        else if (eng_start)
        begin
            m_cnt <= MUL_CNT_W'(FIELD_W);
        end
        else if (!eng_idle)
        begin
            m_cnt <= m_cnt - 1'b1;
        end
    end

    // msb first shift and add
    always_ff @(posedge i_clk)
    begin
        if (eng_start)
        begin
            m_x   <= eng_x;
            m_y   <= eng_y;
            m_acc <= '0;
        end
        else if (!eng_idle)
        begin
            m_acc <= add_mod(add_mod(m_acc, m_acc, i_prime),
                             m_y[FIELD_W-1] ? m_x : '0, i_prime);
            m_y   <= m_y << 1;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state       <= ST_IDLE;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            rsp_valid_q <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        case (op.opcode)
                            GF_MUL:  state <= ST_MUL;
                            GF_DIV:  state <= ST_EXP_CHK;
                            default: rsp_valid_q <= 1'b1;
                        endcase
                    end
                end
                ST_EXP_CHK:
                begin
                    if (exp_q == '0)
                        state <= ST_DIV_MUL;
                    else if (exp_q[0])
                        state <= ST_EXP_MUL;
                    else
                        state <= ST_EXP_SQR;
                end
                ST_EXP_MUL:
                begin
                    if (eng_idle)
                        state <= ST_EXP_SQR;
                end
                ST_EXP_SQR:
                begin
                    if (eng_idle)
                        state <= ST_EXP_CHK;
                end
                default:
                begin
                    if (eng_idle)                   // ST_MUL and ST_DIV_MUL
                    begin
                        rsp_valid_q <= 1'b1;
                        state       <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk)
    begin
        case (state)
            ST_IDLE:
            begin
                if (accept)
                begin
                    if (op.opcode == GF_SUB)
                        rsp_data <= sub_mod(op.operand_a, op.operand_b, i_prime);
                    else
                        rsp_data <= add_mod(op.operand_a, op.operand_b, i_prime);
                    exp_q   <= i_prime - FIELD_W'(2);  // b^(p-2) is the inverse
                    base_q  <= op.operand_b;
                    pow_q   <= FIELD_W'(1);
                    div_a_q <= op.operand_a;
                end
            end
            ST_EXP_MUL:
            begin
                if (eng_idle)
                    pow_q <= m_acc;
            end
            ST_EXP_SQR:
            begin
                if (eng_idle)
                begin
                    base_q <= m_acc;
                    exp_q  <= exp_q >> 1;
                end
            end
            default:
            begin
                if (eng_idle && state != ST_EXP_CHK)
                    rsp_data <= m_acc;
            end
        endcase
    end

    assign op.req_ready = (state == ST_IDLE);
    assign op.result    = rsp_data;
    assign op.rsp_valid = rsp_valid_q;

endmodule

// ==== logic/ecc_point_mult.sv ====
module ecc_point_mult import ecc_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_reset,
    input  logic    i_start,
    input  key_t    i_key,
    input  field_t  i_px,
    input  field_t  i_py,
    input  field_t  i_a,
    input  field_t  i_prime,
    output logic    o_busy,
    output logic    o_done,
    output field_t  o_qx,
    output field_t  o_qy
);

    logic load;

    gf_op_if op_bus ();

    assign load = i_start && !o_busy;               // start ignored while busy

    point_mult_sequencer i_point_mult_sequencer (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (i_start),
        .i_key   (i_key),
        .o_busy  (o_busy),
        .o_done  (o_done),
        .op      (op_bus.sequencer)
    );

    point_register_file i_point_register_file (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_load  (load),
        .i_px    (i_px),
        .i_py    (i_py),
        .i_a     (i_a),
        .o_qx    (o_qx),
        .o_qy    (o_qy),
        .op      (op_bus.regfile)
    );

    gf_arith_unit i_gf_arith_unit (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_prime (i_prime),
        .op      (op_bus.arith)
    );

endmodule

// ==== dv/ecc_ref_model.svh ====
`ifndef ECC_REF_MODEL_SVH
`define ECC_REF_MODEL_SVH

typedef struct packed {
    field_t x;
    field_t y;
} ec_point_t;

function automatic field_t mod_add(field_t a, field_t b, field_t p);
    return field_t'((32'(a) + 32'(b)) % 32'(p));
endfunction

function automatic field_t mod_sub(field_t a, field_t b, field_t p);
    return field_t'((32'(a) + 32'(p) - 32'(b)) % 32'(p));   // operands below p
endfunction

function automatic field_t mod_mul(field_t a, field_t b, field_t p);
    return field_t'((64'(a) * 64'(b)) % 64'(p));
endfunction

function automatic field_t mod_pow(field_t base, field_t e, field_t p);
    field_t r;
    field_t b;
    r = 16'd1;
    b = base;
    for (int i = 0; i < FIELD_W; i++)
    begin
        if (e[i])
            r = mod_mul(r, b, p);
        b = mod_mul(b, b, p);
    end
    return r;
endfunction

// a / b as a * b^(p-2), so b = 0 gives 0
function automatic field_t mod_div(field_t a, field_t b, field_t p);
    return mod_mul(a, mod_pow(b, p - 16'd2, p), p);
endfunction

function automatic ec_point_t point_double(ec_point_t q, field_t a, field_t p);
    ec_point_t r;
    field_t    sq;
    field_t    lam;
    sq    = mod_mul(q.x, q.x, p);
    lam   = mod_div(mod_add(mod_add(mod_add(sq, sq, p), sq, p), a, p),
                    mod_add(q.y, q.y, p), p);
    r.x   = mod_sub(mod_mul(lam, lam, p), mod_add(q.x, q.x, p), p);
    r.y   = mod_sub(mod_mul(lam, mod_sub(q.x, r.x, p), p), q.y, p);
    return r;
endfunction

function automatic ec_point_t point_add(ec_point_t q, ec_point_t pt, field_t p);
    ec_point_t r;
    field_t    lam;
    lam = mod_div(mod_sub(pt.y, q.y, p), mod_sub(pt.x, q.x, p), p);
    r.x = mod_sub(mod_sub(mod_mul(lam, lam, p), q.x, p), pt.x, p);
    r.y = mod_sub(mod_mul(lam, mod_sub(q.x, r.x, p), p), q.y, p);
    return r;
endfunction

// left to right, top key bit taken as 1
function automatic ec_point_t scalar_mult(key_t k, ec_point_t pt, field_t a, field_t p);
    ec_point_t q;
    q = pt;
    for (int i = KEY_W - 2; i >= 0; i--)
    begin
        q = point_double(q, a, p);
        if (k[i])
            q = point_add(q, pt, p);
    end
    return q;
endfunction

`endif

// ==== dv/ecc_point_mult_tb.sv ====
module ecc_point_mult_tb import ecc_pkg::*;
();

    `include "ecc_ref_model.svh"

    localparam int CLK_PERIOD = 4;
    localparam int NUM_RUNS   = 12;
    localparam int RUN_CYCLES = 16384;                  // 7 bits of double plus add
    localparam int NUM_PRIMES = 6;

    logic   i_clk = 1'b0;
    logic   i_reset;
    logic   i_start;
    key_t   i_key;
    field_t i_px;
    field_t i_py;
    field_t i_a;
    field_t i_prime;
    logic   o_busy;
    logic   o_done;
    field_t o_qx;
    field_t o_qy;

    integer    seed;
    ec_point_t expected_q [$];
    string     name_q [$];
    logic      done_prev = 1'b0;
    ec_point_t cur_exp;
    string     cur_name;
    field_t    primes [NUM_PRIMES] = '{16'd97, 16'd251, 16'd1021, 16'd4093,
                                       16'd32749, 16'd65521};

    ecc_point_mult i_ecc_point_mult (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_start (i_start),
        .i_key   (i_key),
        .i_px    (i_px),
        .i_py    (i_py),
        .i_a     (i_a),
        .i_prime (i_prime),
        .o_busy  (o_busy),
        .o_done  (o_done),
        .o_qx    (o_qx),
        .o_qy    (o_qy)
    );

    initial
    begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    task automatic stop_run();
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_error(string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic check_coord(string name, field_t expected, field_t actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected)
        begin
            $display("FAIL %s expected %b actual %b", name, expected, actual);
            stop_run();
        end
    endtask

    task automatic start_run(string name, key_t key, field_t px, field_t py,
                             field_t a, field_t prime);
        ec_point_t pt;
        pt.x = px;
        pt.y = py;
        @(negedge i_clk);
        i_key   = key;
        i_px    = px;
        i_py    = py;
        i_a     = a;
        i_prime = prime;
        i_start = 1'b1;
        expected_q.push_back(scalar_mult(key, pt, a, prime));
        name_q.push_back(name);
        @(negedge i_clk);
        i_start = 1'b0;
        check_flag({name, " busy after start"}, 1'b1, o_busy);
    endtask

    task automatic wait_done();
        while (o_done !== 1'b1)
            @(negedge i_clk);
    endtask

    // result must stay put until the next start
    task automatic hold_check(string name, int cycles);
        field_t held_x;
        field_t held_y;
        held_x = o_qx;
        held_y = o_qy;
        repeat (cycles)
        begin
            @(negedge i_clk);
            check_coord({name, " qx hold"}, held_x, o_qx);
            check_coord({name, " qy hold"}, held_y, o_qy);
            check_flag({name, " done low"}, 1'b0, o_done);
        end
    endtask

    task automatic run_and_check(string name, key_t key, field_t px, field_t py,
                                 field_t a, field_t prime);
        start_run(name, key, px, py, a, prime);
        wait_done();
        hold_check(name, 5);
    endtask

    // compare process
    always @(negedge i_clk)
    begin
        if (o_done === 1'b1)
        begin
            if (done_prev)
                report_error("o_done stayed high for more than one cycle");
            if (expected_q.size() == 0)
                report_error("o_done pulsed without an accepted start");
            cur_name = name_q.pop_front();
            cur_exp  = expected_q.pop_front();
            check_coord({cur_name, " qx"}, cur_exp.x, o_qx);
            check_coord({cur_name, " qy"}, cur_exp.y, o_qy);
            check_flag({cur_name, " busy at done"}, 1'b0, o_busy);
        end
        done_prev = (o_done === 1'b1);
    end

    initial
    begin
        #(NUM_RUNS * RUN_CYCLES * CLK_PERIOD);
        report_error("watchdog timeout, the runs did not finish in time");
    end

    initial
    begin
        key_t   r_key;
        field_t r_p;
        field_t r_px;
        field_t r_py;
        field_t r_a;
        seed    = 32'h4dbb9892;
        i_reset = 1'b1;
        i_start = 1'b0;
        i_key   = '0;
        i_px    = '0;
        i_py    = '0;
        i_a     = '0;
        i_prime = 16'd97;
        repeat (3) @(negedge i_clk);
        i_reset = 1'b0;

        repeat (4)
        begin
            @(negedge i_clk);
            check_flag("idle busy", 1'b0, o_busy);
            check_flag("idle done", 1'b0, o_done);
        end

        run_and_check("double_only", 8'h80, 16'd13, 16'd22, 16'd5, 16'd97);
        run_and_check("double_add", 8'hff, 16'd101, 16'd57, 16'd3, 16'd251);

        for (int n = 0; n < 6; n++)
        begin
            r_p   = primes[$unsigned($random(seed)) % NUM_PRIMES];
            r_key = key_t'($random(seed)) | 8'h80;
            r_px  = field_t'($unsigned($random(seed)) % r_p);
            r_py  = field_t'($unsigned($random(seed)) % r_p);
            r_a   = field_t'($unsigned($random(seed)) % r_p);
            run_and_check($sformatf("random_%0d", n), r_key, r_px, r_py, r_a, r_p);
        end

        // second start mid run must be dropped
        start_run("ignored_start", 8'ha5, 16'd700, 16'd333, 16'd17, 16'd1021);
        repeat (40) @(negedge i_clk);
        check_flag("ignored_start busy", 1'b1, o_busy);
        i_key   = 8'h3c;
        i_start = 1'b1;
        @(negedge i_clk);
        i_start = 1'b0;
        i_key   = 8'ha5;
        wait_done();
        hold_check("ignored_start", 5);

        run_and_check("b2b_0", 8'hc3, 16'd4000, 16'd12, 16'd2, 16'd4093);
        run_and_check("b2b_1", 8'h9a, 16'd30001, 16'd777, 16'd31000, 16'd32749);
        run_and_check("b2b_2", 8'hd6, 16'd65000, 16'd4242, 16'd7, 16'd65521);

        repeat (4) @(negedge i_clk);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+dv
logic/ecc_pkg.sv
logic/gf_op_if.sv
logic/point_mult_sequencer.sv
logic/point_register_file.sv
logic/gf_arith_unit.sv
logic/ecc_point_mult.sv
dv/ecc_point_mult_tb.sv

// ==== Makefile ====
# Verilator flow for the scalar point multiplier testbench

VERILATOR ?= verilator
FILELIST  ?= filelist.f
TOP       ?= ecc_point_mult_tb
LOG       ?= sim.log
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing -Wno-fatal
PASS_MSG  := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
